// ==== compile.f ====
source/fifo_pkg.sv
source/sync_fifo.sv
source/rate_limiter.sv
source/apb_fifo_regs.sv
source/fifo_subsystem.sv
sim/fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the APB FIFO testbench with Verilator, runs it and logs to sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module fifo_tb \
  -o fifo_tb_sim > sim.log 2>&1 \
  && ./obj_dir/fifo_tb_sim >> sim.log 2>&1 \
  || echo "TESTS FAILED" >> sim.log

grep -q "TESTS PASSED" sim.log || echo "TESTS FAILED" >> sim.log
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1
exit 0

// ==== sim/fifo_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the APB FIFO subsystem, seeded random APB traffic
// checked against a queue model and a per-window usage model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fifo_tb
  import fifo_pkg::*;
();

  localparam int DEPTH          = 8;
  localparam int WINDOW_LEN     = 16;
  localparam int NUM_TRANSFERS  = 400;
  localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * (WINDOW_LEN + 4);
  localparam int SAMPLE_DELAY   = 10;   // outputs settled after the falling edge

  logic     clk;
  logic     rst;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  integer seed = 32'hd63a6506;
  int     cyc;          // cycles since reset release
  int     errors;
  int     checks;
  int     transfers;

  // reference model
  word_t      model_q[$];
  logic [7:0] wr_quota_m;
  logic [7:0] rd_quota_m;
  int         wr_win;
  int         wr_used;
  int         rd_win;
  int         rd_used;

  fifo_subsystem #(
    .DEPTH      (DEPTH),
    .WINDOW_LEN (WINDOW_LEN)
  ) UUT (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // zero in the first cycle after release, like the window position
  always @(posedge clk) begin
    if (!rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  initial begin : watchdog
    wait (rst === 1'b1);
    while (cyc < TIMEOUT_CYCLES) begin
      @(posedge clk);
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("** Error at %0t: %s", $time, what);
    end
  endtask

  // answered in the first access cycle
  task automatic check_immediate(input logic exp_err, input logic err,
                                 input int t0, input int t1);
    check_value("apb_rsp.pslverr", 32'(exp_err), 32'(err));
    check_value("completion cycle", 32'(t0), 32'(t1));
  endtask

  // one APB transfer, setup then access until pready
  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input word_t wdata, output word_t rdata,
                              output logic err, output int t0, output int t1);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #(SAMPLE_DELAY);
    t0 = cyc;
    while (!apb_rsp.pready) begin
      @(negedge clk);
      #(SAMPLE_DELAY);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    t1    = cyc;
    transfers++;
  endtask

  // a throttled access waits for the start of the next window
  function automatic int predict_done(input int t0, input int win_rec,
                                      input int used_rec, input logic [7:0] quota);
    int win;
    int used;
    win  = t0 / WINDOW_LEN;
    used = (win_rec == win) ? used_rec : 0;
    if (used < int'(quota)) begin
      return t0;
    end
    return (win + 1) * WINDOW_LEN;
  endfunction

  task automatic count_take(input int t1, input logic [7:0] quota, input string dir,
                            inout int win_rec, inout int used_rec);
    if (win_rec != t1 / WINDOW_LEN) begin
      win_rec  = t1 / WINDOW_LEN;
      used_rec = 0;
    end
    used_rec++;
    check_true(used_rec <= int'(quota), {dir, " count in one window exceeds its quota"});
  endtask

  task automatic push_word();
    word_t wdata;
    word_t rdata;
    logic  err;
    logic  was_full;
    int    t0;
    int    t1;
    wdata    = $random(seed);
    was_full = (model_q.size() == DEPTH - 1);
    apb_transfer(1'b1, ADDR_DATA, wdata, rdata, err, t0, t1);
    if (was_full) begin
      check_immediate(1'b1, err, t0, t1);   // overflow leaves the model as is
    end else begin
      check_value("apb_rsp.pslverr", 32'd0, 32'(err));
      check_value("completion cycle",
                  32'(predict_done(t0, wr_win, wr_used, wr_quota_m)), 32'(t1));
      count_take(t1, wr_quota_m, "push", wr_win, wr_used);
      model_q.push_back(wdata);
    end
  endtask

  task automatic pop_word();
    word_t exp_word;
    word_t rdata;
    logic  err;
    logic  was_empty;
    int    t0;
    int    t1;
    was_empty = (model_q.size() == 0);
    apb_transfer(1'b0, ADDR_DATA, '0, rdata, err, t0, t1);
    if (was_empty) begin
      check_immediate(1'b1, err, t0, t1);
      check_value("apb_rsp.prdata", 32'd0, rdata);
    end else begin
      exp_word = model_q.pop_front();
      check_value("apb_rsp.pslverr", 32'd0, 32'(err));
      check_value("completion cycle",
                  32'(predict_done(t0, rd_win, rd_used, rd_quota_m)), 32'(t1));
      check_value("apb_rsp.prdata", exp_word, rdata);
      count_take(t1, rd_quota_m, "pop", rd_win, rd_used);
    end
  endtask

  task automatic read_status();
    word_t exp_word;
    word_t rdata;
    logic  err;
    int    count;
    int    t0;
    int    t1;
    count    = model_q.size();
    exp_word = {16'd0, 8'(count), 6'd0, count == DEPTH - 1, count == 0};
    apb_transfer(1'b0, ADDR_STATUS, '0, rdata, err, t0, t1);
    check_immediate(1'b0, err, t0, t1);
    check_value("STATUS", exp_word, rdata);
  endtask

  task automatic read_quota();
    word_t rdata;
    logic  err;
    int    t0;
    int    t1;
    apb_transfer(1'b0, ADDR_QUOTA, '0, rdata, err, t0, t1);
    check_immediate(1'b0, err, t0, t1);
    check_value("QUOTA", {16'd0, rd_quota_m, wr_quota_m}, rdata);
  endtask

  task automatic write_quota();
    logic [7:0] wr_new;
    logic [7:0] rd_new;
    word_t      rdata;
    logic       err;
    int         t0;
    int         t1;
    wr_new = 8'(rand_below(9));
    rd_new = 8'(rand_below(9));
    apb_transfer(1'b1, ADDR_QUOTA, {16'd0, rd_new, wr_new}, rdata, err, t0, t1);
    check_immediate(1'b0, err, t0, t1);
    wr_quota_m = wr_new;
    rd_quota_m = rd_new;
  endtask

  // STATUS is read only, a write is dropped without error
  task automatic write_status();
    word_t rdata;
    logic  err;
    int    t0;
    int    t1;
    apb_transfer(1'b1, ADDR_STATUS, $random(seed), rdata, err, t0, t1);
    check_immediate(1'b0, err, t0, t1);
  endtask

  task automatic access_unmapped();
    logic [3:0] addr;
    word_t      rdata;
    logic       err;
    int         t0;
    int         t1;
    do begin
      addr = 4'(rand_below(16));
    end while (addr == ADDR_DATA || addr == ADDR_STATUS || addr == ADDR_QUOTA);
    apb_transfer(1'(rand_below(2)), addr, $random(seed), rdata, err, t0, t1);
    check_immediate(1'b1, err, t0, t1);
  endtask

  initial begin : stimulus
    int pick;
    rst        = 1'b0;
    apb_req    = '0;
    errors     = 0;
    checks     = 0;
    transfers  = 0;
    wr_quota_m = 8'(WINDOW_LEN / 2);
    rd_quota_m = 8'(WINDOW_LEN / 2);
    wr_win     = -1;
    wr_used    = 0;
    rd_win     = -1;
    rd_used    = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    #(SAMPLE_DELAY);
    check_value("apb_rsp.pready", 32'd0, 32'(apb_rsp.pready));
    check_value("apb_rsp.pslverr", 32'd0, 32'(apb_rsp.pslverr));
    read_quota();      // reset quotas
    read_status();
    pop_word();        // underflow on the empty FIFO
    for (int i = 0; i < NUM_TRANSFERS; i++) begin
      pick = rand_below(100);
      // a zero quota would stall a DATA access for good
      if (pick < 40) begin
        if (model_q.size() < DEPTH - 1 && wr_quota_m == 8'd0) begin
          read_quota();
        end else begin
          push_word();
        end
      end else if (pick < 80) begin
        if (model_q.size() > 0 && rd_quota_m == 8'd0) begin
          read_quota();
        end else begin
          pop_word();
        end
      end else if (pick < 88) begin
        read_status();
      end else if (pick < 92) begin
        read_quota();
      end else if (pick < 96) begin
        write_quota();
      end else if (pick < 98) begin
        write_status();
      end else begin
        access_unmapped();
      end
    end
    @(negedge clk);
    apb_req = '0;
    @(negedge clk);
    $display("transfers: %0d, checks: %0d, errors: %0d", transfers, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/apb_fifo_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave with DATA, STATUS and QUOTA registers
// DATA accesses become FIFO push and pop, throttled by the rate limiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module apb_fifo_regs
  import fifo_pkg::*;
#(
  parameter int DEPTH      = 8,
  parameter int WINDOW_LEN = 16
) (
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire apb_req_t     apb_req,
  input  wire word_t        pop_data,
  input  wire fifo_status_t status,
  input  wire logic         wr_allow,
  input  wire logic         rd_allow,
  output apb_rsp_t          apb_rsp,
  output logic              push,
  output word_t             push_data,
  output logic              pop,
  output quota_t            quota,
  output logic              wr_take,
  output logic              rd_take
);

  localparam logic [7:0] QUOTA_RST = 8'(WINDOW_LEN / 2);

  logic  access;
  logic  quota_wr;
  word_t status_word;

  assign access = apb_req.psel && apb_req.penable;

  // STATUS register image
  assign status_word = {16'd0, status.count, 6'd0, status.full, status.empty};

  always_comb begin
    apb_rsp.prdata  = '0;
    apb_rsp.pready  = 1'b0;
    apb_rsp.pslverr = 1'b0;
    push            = 1'b0;
    pop             = 1'b0;
    if (access) begin
      case (apb_req.paddr)
        ADDR_DATA: begin
          if (apb_req.pwrite) begin
            if (status.full) begin   // overflow, nothing stored
              apb_rsp.pready  = 1'b1;
              apb_rsp.pslverr = 1'b1;
            end else if (wr_allow) begin
              apb_rsp.pready = 1'b1;
              push           = 1'b1;
            end
          end else begin
            if (status.empty) begin  // underflow, prdata stays zero
              apb_rsp.pready  = 1'b1;
              apb_rsp.pslverr = 1'b1;
            end else if (rd_allow) begin
              apb_rsp.pready = 1'b1;
              apb_rsp.prdata = pop_data;
              pop            = 1'b1;
            end
          end
        end
        ADDR_STATUS: begin
          apb_rsp.pready = 1'b1;     // writes are dropped
          if (!apb_req.pwrite) begin
            apb_rsp.prdata = status_word;
          end
        end
        ADDR_QUOTA: begin
          apb_rsp.pready = 1'b1;
          if (!apb_req.pwrite) begin
            apb_rsp.prdata = {16'd0, quota};
          end
        end
        default: begin
          apb_rsp.pready  = 1'b1;
          apb_rsp.pslverr = 1'b1;
        end
      endcase
    end
  end

  assign push_data = apb_req.pwdata;
  assign wr_take   = push;
  assign rd_take   = pop;

  assign quota_wr = access && apb_req.pwrite && (apb_req.paddr == ADDR_QUOTA);

  // new quota applies from the next cycle
  always_ff @(posedge clk) begin
    if (!rst) begin
      quota.wr_quota <= QUOTA_RST;
      quota.rd_quota <= QUOTA_RST;
    end else if (quota_wr) begin
      quota <= quota_t'(apb_req.pwdata[15:0]);
    end
  end

  // FIFO traffic only on an accepted access phase
  a_fifo_op_on_access: assert property (@(posedge clk) disable iff (!rst)
    (push || pop) |-> (access && apb_rsp.pready && !apb_rsp.pslverr))
    else $error("apb_fifo_regs: FIFO op outside a completed access");

  // pushes only while the FIFO is below capacity
  a_push_below_depth: assert property (@(posedge clk) disable iff (!rst)
    push |-> (status.count < 8'(DEPTH - 1)))
    else $error("apb_fifo_regs: push with the FIFO at capacity");

  // a lone push shows up in the count one cycle later
  a_push_counted: assert property (@(posedge clk) disable iff (!rst)
    (push && !pop) |=> (status.count == $past(status.count) + 8'd1))
    else $error("apb_fifo_regs: push not reflected in count");

endmodule

`default_nettype wire

// ==== source/fifo_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and register map of the APB FIFO subsystem
// imported by every RTL module and by the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fifo_pkg;

  // one FIFO data word
  typedef logic [31:0] word_t;

  // APB requester side
  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [3:0] paddr;   // byte offset
    word_t      pwdata;
  } apb_req_t;

  // APB completer side
  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  // QUOTA register layout, wr in the low byte
  typedef struct packed {
    logic [7:0] rd_quota;
    logic [7:0] wr_quota;
  } quota_t;

  // occupancy seen by the register slave
  typedef struct packed {
    logic [7:0] count;
    logic       full;
    logic       empty;
  } fifo_status_t;

  localparam logic [3:0] ADDR_DATA   = 4'h0;
  localparam logic [3:0] ADDR_STATUS = 4'h4;
  localparam logic [3:0] ADDR_QUOTA  = 4'h8;

endpackage

`default_nettype wire

// ==== source/fifo_subsystem.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rate limited FIFO behind an APB slave, top level of the subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fifo_subsystem
  import fifo_pkg::*;
#(
  parameter int DEPTH      = 8,    // power of two, 4 to 128
  parameter int WINDOW_LEN = 16    // 4 to 255 cycles
) (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire apb_req_t apb_req,
  output apb_rsp_t      apb_rsp
);

  logic         push;
  logic         pop;
  word_t        push_data;
  word_t        pop_data;
  fifo_status_t status;
  quota_t       quota;
  logic         wr_take;
  logic         rd_take;
  logic         wr_allow;
  logic         rd_allow;

  apb_fifo_regs #(
    .DEPTH      (DEPTH),
    .WINDOW_LEN (WINDOW_LEN)
  ) u_regs (
    .clk       (clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .pop_data  (pop_data),
    .status    (status),
    .wr_allow  (wr_allow),
    .rd_allow  (rd_allow),
    .apb_rsp   (apb_rsp),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .quota     (quota),
    .wr_take   (wr_take),
    .rd_take   (rd_take)
  );

  rate_limiter #(
    .WINDOW_LEN (WINDOW_LEN)
  ) u_limiter (
    .clk      (clk),
    .rst      (rst),
    .quota    (quota),
    .wr_take  (wr_take),
    .rd_take  (rd_take),
    .wr_allow (wr_allow),
    .rd_allow (rd_allow)
  );

  sync_fifo #(
    .DEPTH (DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .status    (status)
  );

endmodule

`default_nettype wire

// ==== source/rate_limiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-window push and pop budget, allow stays high while usage is below quota
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module rate_limiter
  import fifo_pkg::*;
#(
  parameter int WINDOW_LEN = 16
) (
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire quota_t quota,
  input  wire logic   wr_take,
  input  wire logic   rd_take,
  output logic        wr_allow,
  output logic        rd_allow
);

  localparam logic [7:0] WIN_LAST = 8'(WINDOW_LEN - 1);

  logic [7:0] win_cnt;
  logic       win_last;
  logic [7:0] wr_used;
  logic [7:0] rd_used;

  assign win_last = (win_cnt == WIN_LAST);

  // free running, zero in the first cycle after reset
  always_ff @(posedge clk) begin
    if (!rst) begin
      win_cnt <= '0;
    end else if (win_last) begin
      win_cnt <= '0;
    end else begin
      win_cnt <= win_cnt + 8'd1;
    end
  end

  // usage restarts with each window
  always_ff @(posedge clk) begin
    if (!rst || win_last) begin
      wr_used <= '0;
    end else if (wr_take) begin
      wr_used <= wr_used + 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst || win_last) begin
      rd_used <= '0;
    end else if (rd_take) begin
      rd_used <= rd_used + 8'd1;
    end
  end

  // a lowered quota closes the window at once
  assign wr_allow = (wr_used < quota.wr_quota);
  assign rd_allow = (rd_used < quota.rd_quota);

  // the slave only takes what was allowed
  a_wr_take_allowed: assert property (@(posedge clk) disable iff (!rst)
    wr_take |-> wr_allow)
    else $error("rate_limiter: push beyond write quota");

  a_rd_take_allowed: assert property (@(posedge clk) disable iff (!rst)
    rd_take |-> rd_allow)
    else $error("rate_limiter: pop beyond read quota");

  a_window_range: assert property (@(posedge clk) disable iff (!rst)
    win_cnt < 8'(WINDOW_LEN))
    else $error("rate_limiter: window counter out of range");

endmodule

`default_nettype wire

// ==== source/sync_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single clock pointer FIFO, one slot kept empty, head word shown at pop_data
// push and pop are expected to respect full and empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module sync_fifo
  import fifo_pkg::*;
#(
  parameter int DEPTH = 8
) (
  input  wire logic   clk,
  input  wire logic   rst,
  input  wire logic   push,
  input  wire word_t  push_data,
  input  wire logic   pop,
  output word_t        pop_data,
  output fifo_status_t status
);

  localparam int AW = $clog2(DEPTH);

  word_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW-1:0] wr_ptr_inc;
  logic [AW-1:0] rd_ptr_inc;
  logic [AW-1:0] ptr_diff;

  logic empty;
  logic full;
  logic do_push;
  logic do_pop;

  assign wr_ptr_inc = wr_ptr + 1'b1;
  assign rd_ptr_inc = rd_ptr + 1'b1;
  assign ptr_diff   = wr_ptr - rd_ptr;   // wraps, always below DEPTH

  // one-slot-empty flags
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr_inc == rd_ptr);

  // guard the storage against a stray request
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr_inc;
    end
  end

  // storage has no reset
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign pop_data = mem[rd_ptr];   // head word, no read latency

  always_comb begin
    status.empty = empty;
    status.full  = full;
    status.count = 8'(ptr_diff);
  end

  // full and empty are exclusive
  a_flags_exclusive: assert property (@(posedge clk) !(full && empty))
    else $error("sync_fifo: full and empty both high");

  // requests from the register slave must honour the flags
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst) !(push && full))
    else $error("sync_fifo: push while full");

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst) !(pop && empty))
    else $error("sync_fifo: pop while empty");

  // pointers hold or advance by one slot
  a_wr_ptr_step: assert property (@(posedge clk) disable iff (!rst)
    (wr_ptr == $past(wr_ptr)) || (wr_ptr == AW'($past(wr_ptr) + 1'b1)))
    else $error("sync_fifo: write pointer jumped");

  a_rd_ptr_step: assert property (@(posedge clk) disable iff (!rst)
    (rd_ptr == $past(rd_ptr)) || (rd_ptr == AW'($past(rd_ptr) + 1'b1)))
    else $error("sync_fifo: read pointer jumped");

  // a reset cycle leaves both pointers at zero
  a_reset_ptrs: assert property (@(posedge clk)
    !rst |=> (wr_ptr == '0 && rd_ptr == '0))
    else $error("sync_fifo: pointers not cleared by reset");

endmodule

`default_nettype wire
